/* filelist.f */
+incdir+verif
source/lsu_pkg.sv
source/load_store_buffer.sv
source/data_memory.sv
source/lsu_top.sv
verif/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# exit status is nonzero when the run ends in $fatal
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module lsu_tb \
    -o lsu_sim

./obj_dir/lsu_sim

/* verif/lsu_tb_table.svh */
`ifndef LSU_TB_TABLE_SVH
`define LSU_TB_TABLE_SVH

// columns: kind, op, imm, rd nick, rs1 nick, rs1 data, rs2 nick, rs2 data
// wait rows put the access address in imm, store waits also the store data
// quiet rows put a cycle count in imm, full rows the expected full
task automatic build_table();
    // stores of each width, then loads of each width and sign
    add_row(k_disp,   op_sw, 32'h0,  1, 0, 32'h40, 0, 32'h8421_f0e7);
    add_row(k_commit, 0,     0,      1, 0, 0,      0, 0);
    add_row(k_wait,   op_sw, 32'h40, 1, 0, 0,      0, 32'h8421_f0e7);
    add_row(k_disp,   op_sb, 32'h1,  2, 0, 32'h40, 0, 32'h0000_005a);
    add_row(k_commit, 0,     0,      2, 0, 0,      0, 0);
    add_row(k_wait,   op_sb, 32'h41, 2, 0, 0,      0, 32'h0000_005a);
    add_row(k_disp,   op_sh, 32'h6,  3, 0, 32'h40, 0, 32'h1234_beef);
    add_row(k_commit, 0,     0,      3, 0, 0,      0, 0);
    add_row(k_wait,   op_sh, 32'h46, 3, 0, 0,      0, 32'h1234_beef);
    add_row(k_disp,   op_lb,  32'h3, 4, 0, 32'h40, 0, 0);
    add_row(k_wait,   op_lb,  32'h43, 4, 0, 0,     0, 0);
    add_row(k_disp,   op_lbu, 32'h0, 5, 0, 32'h40, 0, 0);
    add_row(k_wait,   op_lbu, 32'h40, 5, 0, 0,     0, 0);
    add_row(k_disp,   op_lh,  32'h2, 6, 0, 32'h44, 0, 0);
    add_row(k_wait,   op_lh,  32'h46, 6, 0, 0,     0, 0);
    add_row(k_disp,   op_lhu, 32'h0, 7, 0, 32'h40, 0, 0);
    add_row(k_wait,   op_lhu, 32'h40, 7, 0, 0,     0, 0);
    add_row(k_disp,   op_lw,  32'h4, 1, 0, 32'h40, 0, 0);
    add_row(k_wait,   op_lw,  32'h44, 1, 0, 0,     0, 0);

    // pending base from execute, then a load chained on a load
    add_row(k_disp,   op_sw, 32'h8c, 2, 0, 0,      0, 32'hcafe_0123);
    add_row(k_commit, 0,     0,      2, 0, 0,      0, 0);
    add_row(k_wait,   op_sw, 32'h8c, 2, 0, 0,      0, 32'hcafe_0123);
    add_row(k_disp,   op_sw, 32'h80, 3, 0, 0,      0, 32'h0000_0088);
    add_row(k_commit, 0,     0,      3, 0, 0,      0, 0);
    add_row(k_wait,   op_sw, 32'h80, 3, 0, 0,      0, 32'h0000_0088);
    add_row(k_disp,   op_lw, 32'h0,  4, 6, 0,      0, 0);
    add_row(k_disp,   op_lw, 32'h4,  5, 4, 0,      0, 0);
    add_row(k_quiet,  0,     8,      0, 0, 0,      0, 0);
    add_row(k_exec,   0,     0,      6, 0, 32'h80, 0, 0);
    add_row(k_wait,   op_lw, 32'h80, 4, 0, 0,      0, 0);
    add_row(k_wait,   op_lw, 32'h8c, 5, 0, 0,      0, 0);

    // committed store waits for its data operand
    add_row(k_disp,   op_sw, 32'h90, 6, 0, 0,      7, 0);
    add_row(k_commit, 0,     0,      6, 0, 0,      0, 0);
    add_row(k_quiet,  0,     8,      0, 0, 0,      0, 0);
    add_row(k_exec,   0,     0,      7, 0, 32'h1122_3344, 0, 0);
    add_row(k_wait,   op_sw, 32'h90, 6, 0, 0,      0, 32'h1122_3344);
    add_row(k_disp,   op_lw, 32'h0,  7, 0, 32'h90, 0, 0);
    add_row(k_wait,   op_lw, 32'h90, 7, 0, 0,      0, 0);

    // store held back until commit
    add_row(k_disp,   op_sw,  32'h0,  1, 0, 32'ha0, 0, 32'h0000_0077);
    add_row(k_quiet,  0,      8,      0, 0, 0,      0, 0);
    add_row(k_disp,   op_lw,  32'h0,  2, 0, 32'ha0, 0, 0);
    add_row(k_wait,   op_lw,  32'ha0, 2, 0, 0,      0, 0);
    add_row(k_commit, 0,      0,      1, 0, 0,      0, 0);
    add_row(k_wait,   op_sw,  32'ha0, 1, 0, 0,      0, 32'h0000_0077);
    add_row(k_disp,   op_lbu, 32'h0,  3, 0, 32'ha0, 0, 0);
    add_row(k_wait,   op_lbu, 32'ha0, 3, 0, 0,      0, 0);

    // fill all seven tags, then clear
    for (int t = 1; t <= 6; t++) begin
        add_row(k_disp, op_lw, 32'h0, t, 7, 0, 0, 0);
    end
    // non-memory op on the last free tag keeps full low
    add_row(k_disp,   4'd15, 32'h0,  7, 0, 32'h40, 0, 0);
    add_row(k_full,   0,     0,      0, 0, 0,      0, 0);
    add_row(k_disp,   op_lw, 32'h0,  7, 1, 0,      0, 0);
    add_row(k_full,   0,     1,      0, 0, 0,      0, 0);
    add_row(k_clear,  0,     0,      0, 0, 0,      0, 0);
    add_row(k_full,   0,     0,      0, 0, 0,      0, 0);
    add_row(k_exec,   0,     0,      7, 0, 32'h40, 0, 0);
    add_row(k_quiet,  0,     10,     0, 0, 0,      0, 0);

    // stall with ready loads
    add_row(k_disp,   op_lw, 32'h0,  1, 6, 0,      0, 0);
    add_row(k_disp,   op_lw, 32'h4,  2, 6, 0,      0, 0);
    add_row(k_exec,   0,     0,      6, 0, 32'h40, 0, 0);
    add_row(k_stall,  0,     0,      0, 0, 0,      0, 0);
    add_row(k_quiet,  0,     10,     0, 0, 0,      0, 0);
    add_row(k_run,    0,     0,      0, 0, 0,      0, 0);
    add_row(k_wait,   op_lw, 32'h40, 1, 0, 0,      0, 0);
    add_row(k_wait,   op_lw, 32'h44, 2, 0, 0,      0, 0);

    // opcodes outside the memory set are ignored
    add_row(k_disp,   4'd0,  32'h0,  3, 0, 32'h40, 0, 0);
    add_row(k_disp,   4'd15, 32'h0,  4, 0, 32'h40, 0, 0);
    add_row(k_quiet,  0,     8,      0, 0, 0,      0, 0);
    add_row(k_disp,   op_lw, 32'h8,  3, 0, 32'h40, 0, 0);
    add_row(k_wait,   op_lw, 32'h48, 3, 0, 0,      0, 0);
endtask

`endif

/* verif/lsu_tb.sv */
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    // row kinds used by the stimulus table
    localparam int k_disp   = 0;
    localparam int k_exec   = 1;
    localparam int k_commit = 2;
    localparam int k_wait   = 3;
    localparam int k_stall  = 4;
    localparam int k_run    = 5;
    localparam int k_clear  = 6;
    localparam int k_quiet  = 7;
    localparam int k_full   = 8;

    logic               clk;
    logic               reset;
    logic               rdy;
    logic               clr;
    logic               dp_en;
    logic [op_w-1:0]    dp_op;
    logic [data_w-1:0]  dp_imm;
    logic [nick_w-1:0]  dp_rd_nick;
    logic [nick_w-1:0]  dp_rs1_nick;
    logic [data_w-1:0]  dp_rs1_data;
    logic [nick_w-1:0]  dp_rs2_nick;
    logic [data_w-1:0]  dp_rs2_data;
    logic               ex_en;
    logic [nick_w-1:0]  ex_nick;
    logic [data_w-1:0]  ex_data;
    logic               rob_store_en;
    logic [nick_w-1:0]  rob_store_nick;
    logic               cdb_en;
    logic [nick_w-1:0]  cdb_nick;
    logic [data_w-1:0]  cdb_data;
    logic               full;

    // table columns
    int                 row_kind [$];
    logic [31:0]        row_op   [$];
    logic [31:0]        row_imm  [$];
    logic [31:0]        row_rd   [$];
    logic [31:0]        row_n1   [$];
    logic [31:0]        row_d1   [$];
    logic [31:0]        row_n2   [$];
    logic [31:0]        row_d2   [$];

    // broadcasts seen on the bus, oldest first
    logic [nick_w-1:0]  seen_nick [$];
    logic [data_w-1:0]  seen_data [$];

    logic [31:0]        ref_mem [mem_words];

    lsu_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .rdy            (rdy),
        .clr            (clr),
        .dp_en          (dp_en),
        .dp_op          (dp_op),
        .dp_imm         (dp_imm),
        .dp_rd_nick     (dp_rd_nick),
        .dp_rs1_nick    (dp_rs1_nick),
        .dp_rs1_data    (dp_rs1_data),
        .dp_rs2_nick    (dp_rs2_nick),
        .dp_rs2_data    (dp_rs2_data),
        .ex_en          (ex_en),
        .ex_nick        (ex_nick),
        .ex_data        (ex_data),
        .rob_store_en   (rob_store_en),
        .rob_store_nick (rob_store_nick),
        .cdb_en         (cdb_en),
        .cdb_nick       (cdb_nick),
        .cdb_data       (cdb_data),
        .full           (full)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (cdb_en === 1'b1) begin
            seen_nick.push_back(cdb_nick);
            seen_data.push_back(cdb_data);
        end
    end

    task automatic add_row(input int kind, input logic [31:0] op, input logic [31:0] imm,
                           input logic [31:0] rd, input logic [31:0] n1, input logic [31:0] d1,
                           input logic [31:0] n2, input logic [31:0] d2);
        row_kind.push_back(kind);
        row_op.push_back(op);
        row_imm.push_back(imm);
        row_rd.push_back(rd);
        row_n1.push_back(n1);
        row_d1.push_back(d1);
        row_n2.push_back(n2);
        row_d2.push_back(d2);
    endtask

    `include "lsu_tb_table.svh"

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // sub-word store into an old word, field picked by the low address bits
    function automatic logic [31:0] merge_ref(input logic [31:0] old, input logic [31:0] addr,
                                              input logic [3:0] op, input logic [31:0] data);
        logic [31:0] mask;
        logic [4:0]  sh;
        sh   = 5'd0;
        mask = 32'hffff_ffff;
        if (op == op_sb) begin
            sh   = {addr[1:0], 3'b000};
            mask = 32'h0000_00ff << sh;
        end else if (op == op_sh) begin
            sh   = {addr[1], 4'b0000};
            mask = 32'h0000_ffff << sh;
        end
        return (old & ~mask) | ((data << sh) & mask);
    endfunction

    function automatic logic [31:0] extract_ref(input logic [31:0] word, input logic [31:0] addr,
                                                input logic [3:0] op);
        logic [31:0] w;
        w = word;
        if (op == op_lb || op == op_lbu) begin
            w = word >> {addr[1:0], 3'b000};
        end else if (op == op_lh || op == op_lhu) begin
            w = word >> {addr[1], 4'b0000};
        end
        case (op)
            op_lb:   return {{24{w[7]}}, w[7:0]};
            op_lbu:  return {24'h0, w[7:0]};
            op_lh:   return {{16{w[15]}}, w[15:0]};
            op_lhu:  return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic wait_cdb(input logic [nick_w-1:0] nick, input logic [data_w-1:0] data);
        int                 cycles;
        logic [nick_w-1:0]  got_nick;
        logic [data_w-1:0]  got_data;
        cycles = 0;
        while (seen_nick.size() == 0 && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        if (seen_nick.size() == 0) begin
            report_fail($sformatf("no broadcast arrived for tag %0d within 50 cycles", nick));
        end else begin
            got_nick = seen_nick.pop_front();
            got_data = seen_data.pop_front();
            assert (got_nick == nick) else
                report_fail($sformatf("** Error cdb_nick got 0x%h expected 0x%h", got_nick, nick));
            assert (got_data == data) else
                report_fail($sformatf("** Error cdb_data got 0x%h expected 0x%h", got_data, data));
            if (cycles > 0) begin
                #5;
            end
        end
    endtask

    task automatic apply_row(input int i);
        logic [31:0] addr;
        logic [5:0]  idx;
        addr = row_imm[i];
        idx  = addr[7:2];
        case (row_kind[i])
            k_disp: begin
                dp_en       = 1'b1;
                dp_op       = row_op[i][op_w-1:0];
                dp_imm      = row_imm[i];
                dp_rd_nick  = row_rd[i][nick_w-1:0];
                dp_rs1_nick = row_n1[i][nick_w-1:0];
                dp_rs1_data = row_d1[i];
                dp_rs2_nick = row_n2[i][nick_w-1:0];
                dp_rs2_data = row_d2[i];
                @(posedge clk);
                #5;
                dp_en = 1'b0;
            end
            k_exec: begin
                ex_en   = 1'b1;
                ex_nick = row_rd[i][nick_w-1:0];
                ex_data = row_d1[i];
                @(posedge clk);
                #5;
                ex_en = 1'b0;
            end
            k_commit: begin
                rob_store_en   = 1'b1;
                rob_store_nick = row_rd[i][nick_w-1:0];
            end
            k_wait: begin
                if (row_op[i][3:0] == op_sb || row_op[i][3:0] == op_sh
                        || row_op[i][3:0] == op_sw) begin
                    wait_cdb(row_rd[i][nick_w-1:0], '0);
                    ref_mem[idx] = merge_ref(ref_mem[idx], addr, row_op[i][3:0], row_d2[i]);
                    rob_store_en = 1'b0;
                end else begin
                    wait_cdb(row_rd[i][nick_w-1:0],
                             extract_ref(ref_mem[idx], addr, row_op[i][3:0]));
                end
            end
            k_stall: rdy = 1'b0;
            k_run:   rdy = 1'b1;
            k_clear: begin
                clr = 1'b1;
                @(posedge clk);
                #5;
                clr = 1'b0;
            end
            k_quiet: begin
                repeat (row_imm[i]) @(posedge clk);
                #5;
                assert (seen_nick.size() == 0) else
                    report_fail("a broadcast arrived while none was expected");
            end
            default: begin
                assert (full == row_imm[i][0]) else
                    report_fail($sformatf("** Error full got 0x%h expected 0x%h",
                                          full, row_imm[i][0]));
            end
        endcase
    endtask

    initial begin
        int idle;
        void'($urandom(62378));
        clk            = 1'b0;
        reset          = 1'b1;
        rdy            = 1'b1;
        clr            = 1'b0;
        dp_en          = 1'b0;
        dp_op          = '0;
        dp_imm         = '0;
        dp_rd_nick     = '0;
        dp_rs1_nick    = '0;
        dp_rs1_data    = '0;
        dp_rs2_nick    = '0;
        dp_rs2_data    = '0;
        ex_en          = 1'b0;
        ex_nick        = '0;
        ex_data        = '0;
        rob_store_en   = 1'b0;
        rob_store_nick = '0;
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = '0;
        end
        build_table();
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;
        for (int i = 0; i < row_kind.size(); i++) begin
            // some slack before each dispatch
            if (row_kind[i] == k_disp) begin
                idle = int'($urandom_range(2, 0));
                repeat (idle) begin
                    @(posedge clk);
                    #5;
                end
            end
            apply_row(i);
        end
        repeat (10) @(posedge clk);
        if (seen_nick.size() != 0) begin
            report_fail("a broadcast arrived after the last table row");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* source/lsu_top.sv */
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 rdy,
    input  wire                 clr,

    input  wire                 dp_en,
    input  wire  [op_w-1:0]     dp_op,
    input  wire  [data_w-1:0]   dp_imm,
    input  wire  [nick_w-1:0]   dp_rd_nick,
    input  wire  [nick_w-1:0]   dp_rs1_nick,
    input  wire  [data_w-1:0]   dp_rs1_data,
    input  wire  [nick_w-1:0]   dp_rs2_nick,
    input  wire  [data_w-1:0]   dp_rs2_data,

    input  wire                 ex_en,
    input  wire  [nick_w-1:0]   ex_nick,
    input  wire  [data_w-1:0]   ex_data,

    input  wire                 rob_store_en,
    input  wire  [nick_w-1:0]   rob_store_nick,

    output logic                cdb_en,
    output logic [nick_w-1:0]   cdb_nick,
    output logic [data_w-1:0]   cdb_data,

    output logic                full
);

    // buffer to memory
    logic               mem_ready;
    logic               req_en;
    logic               req_store;
    logic               req_signed;
    logic [nick_w-1:0]  req_nick;
    logic [len_w-1:0]   req_len;
    logic [addr_w-1:0]  req_addr;
    logic [data_w-1:0]  req_data;

    // memory back to buffer
    logic               done_en;
    logic [nick_w-1:0]  done_nick;
    logic [data_w-1:0]  done_data;

    load_store_buffer slb0 (
        .clk            (clk),
        .reset          (reset),
        .rdy            (rdy),
        .clr            (clr),
        .dp_en          (dp_en),
        .dp_op          (dp_op),
        .dp_imm         (dp_imm),
        .dp_rd_nick     (dp_rd_nick),
        .dp_rs1_nick    (dp_rs1_nick),
        .dp_rs1_data    (dp_rs1_data),
        .dp_rs2_nick    (dp_rs2_nick),
        .dp_rs2_data    (dp_rs2_data),
        .ex_en          (ex_en),
        .ex_nick        (ex_nick),
        .ex_data        (ex_data),
        .rob_store_en   (rob_store_en),
        .rob_store_nick (rob_store_nick),
        .mem_ready      (mem_ready),
        .req_en         (req_en),
        .req_store      (req_store),
        .req_signed     (req_signed),
        .req_nick       (req_nick),
        .req_len        (req_len),
        .req_addr       (req_addr),
        .req_data       (req_data),
        .done_en        (done_en),
        .done_nick      (done_nick),
        .done_data      (done_data),
        .cdb_en         (cdb_en),
        .cdb_nick       (cdb_nick),
        .cdb_data       (cdb_data),
        .full           (full)
    );

    data_memory dmem0 (
        .clk        (clk),
        .reset      (reset),
        .mem_ready  (mem_ready),
        .req_en     (req_en),
        .req_store  (req_store),
        .req_signed (req_signed),
        .req_nick   (req_nick),
        .req_len    (req_len),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .done_en    (done_en),
        .done_nick  (done_nick),
        .done_data  (done_data)
    );

endmodule

`default_nettype wire

/* source/data_memory.sv */
`default_nettype none

module data_memory
    import lsu_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,

    output logic                mem_ready,

    input  wire                 req_en,
    input  wire                 req_store,
    input  wire                 req_signed,
    input  wire  [nick_w-1:0]   req_nick,
    input  wire  [len_w-1:0]    req_len,
    input  wire  [addr_w-1:0]   req_addr,
    input  wire  [data_w-1:0]   req_data,

    output logic                done_en,
    output logic [nick_w-1:0]   done_nick,
    output logic [data_w-1:0]   done_data
);

    localparam int idx_w = $clog2(mem_words);
    localparam int cnt_w = $clog2(mem_latency) + 1;

    mem_word_t          mem [mem_words];

    logic               busy;
    logic [cnt_w-1:0]   cnt;

    // request held for the whole access
    logic               lat_store;
    logic               lat_signed;
    logic [nick_w-1:0]  lat_nick;
    logic [len_w-1:0]   lat_len;
    logic [idx_w+1:0]   lat_addr;
    logic [data_w-1:0]  lat_data;
    logic [idx_w-1:0]   lat_idx;

    mem_word_t          cur_word;
    mem_word_t          merged;
    logic [7:0]         pick_b;
    logic [15:0]        pick_h;
    logic [data_w-1:0]  load_val;

    assign mem_ready = !busy;
    assign lat_idx   = lat_addr[idx_w+1:2];

    // store merge and load extraction on the addressed word
    always_comb begin
        cur_word = mem[lat_idx];
        merged   = cur_word;
        pick_b   = cur_word.bytes[lat_addr[1:0]];
        pick_h   = cur_word.halves[lat_addr[1]];
        case (lat_len)
            len_one: begin
                merged.bytes[lat_addr[1:0]] = lat_data[7:0];
                load_val = lat_signed ? {{(data_w-8){pick_b[7]}}, pick_b}
                                      : {{(data_w-8){1'b0}}, pick_b};
            end
            len_two: begin
                merged.halves[lat_addr[1]] = lat_data[15:0];
                load_val = lat_signed ? {{(data_w-16){pick_h[15]}}, pick_h}
                                      : {{(data_w-16){1'b0}}, pick_h};
            end
            default: begin
                merged.word = lat_data;
                load_val    = cur_word.word;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            cnt     <= '0;
            done_en <= 1'b0;
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else begin
            done_en <= 1'b0;
            if (busy) begin
                if (cnt == '0) begin
                    busy      <= 1'b0;
                    done_en   <= 1'b1;
                    done_nick <= lat_nick;
                    done_data <= lat_store ? '0 : load_val;
                    if (lat_store) begin
                        mem[lat_idx] <= merged;
                    end
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end else if (req_en) begin
                // done goes out mem_latency cycles after this one
                busy       <= 1'b1;
                cnt        <= cnt_w'(mem_latency - 2);
                lat_store  <= req_store;
                lat_signed <= req_signed;
                lat_nick   <= req_nick;
                lat_len    <= req_len;
                lat_addr   <= req_addr[idx_w+1:0];
                lat_data   <= req_data;
            end
        end
    end

    // every completion closes a request taken mem_latency cycles before
    a_done_busy: assert property (@(posedge clk) disable iff (reset)
        done_en |-> $past(req_en && mem_ready, mem_latency));

endmodule

`default_nettype wire

/* source/load_store_buffer.sv */
`default_nettype none

module load_store_buffer
    import lsu_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 rdy,
    input  wire                 clr,

    input  wire                 dp_en,
    input  wire  [op_w-1:0]     dp_op,
    input  wire  [data_w-1:0]   dp_imm,
    input  wire  [nick_w-1:0]   dp_rd_nick,
    input  wire  [nick_w-1:0]   dp_rs1_nick,
    input  wire  [data_w-1:0]   dp_rs1_data,
    input  wire  [nick_w-1:0]   dp_rs2_nick,
    input  wire  [data_w-1:0]   dp_rs2_data,

    input  wire                 ex_en,
    input  wire  [nick_w-1:0]   ex_nick,
    input  wire  [data_w-1:0]   ex_data,

    input  wire                 rob_store_en,
    input  wire  [nick_w-1:0]   rob_store_nick,

    input  wire                 mem_ready,
    output logic                req_en,
    output logic                req_store,
    output logic                req_signed,
    output logic [nick_w-1:0]   req_nick,
    output logic [len_w-1:0]    req_len,
    output logic [addr_w-1:0]   req_addr,
    output logic [data_w-1:0]   req_data,

    input  wire                 done_en,
    input  wire  [nick_w-1:0]   done_nick,
    input  wire  [data_w-1:0]   done_data,

    output logic                cdb_en,
    output logic [nick_w-1:0]   cdb_nick,
    output logic [data_w-1:0]   cdb_data,

    output logic                full
);

    logic [slb_entries-1:0] occupied;
    logic [slb_entries-1:0] issued;
    logic [slb_entries-1:0] is_store;
    logic [slb_entries-1:0] rs1_valid;
    logic [slb_entries-1:0] rs2_valid;
    logic [op_w-1:0]        ent_op   [slb_entries];
    logic [data_w-1:0]      ent_imm  [slb_entries];
    logic [nick_w-1:0]      rs1_nick [slb_entries];
    logic [data_w-1:0]      rs1_data [slb_entries];
    logic [nick_w-1:0]      rs2_nick [slb_entries];
    logic [data_w-1:0]      rs2_data [slb_entries];

    // request and broadcast registers, shown on the ports only while rdy
    logic                   req_q;
    logic                   cdb_q;

    // completion that arrived during a stall
    logic                   pend_en;
    logic [nick_w-1:0]      pend_nick;
    logic [data_w-1:0]      pend_data;

    logic                   fin_en;
    logic [nick_w-1:0]      fin_nick;
    logic [data_w-1:0]      fin_data;

    logic                   sel_en;
    logic                   sel_store;
    logic [nick_w-1:0]      sel_nick;
    logic                   dp_take;

    function automatic logic is_mem_op(input logic [op_w-1:0] op);
        case (op)
            op_lb, op_lh, op_lw, op_lbu, op_lhu,
            op_sb, op_sh, op_sw: is_mem_op = 1'b1;
            default:             is_mem_op = 1'b0;
        endcase
    endfunction

    function automatic logic [len_w-1:0] len_of(input logic [op_w-1:0] op);
        case (op)
            op_lb, op_lbu, op_sb: len_of = len_one;
            op_lh, op_lhu, op_sh: len_of = len_two;
            default:              len_of = len_four;
        endcase
    endfunction

    assign dp_take = rdy && dp_en && is_mem_op(dp_op);

    // tags 1 to 7 all taken
    assign full = &occupied[slb_entries-1:1];

    assign req_en = req_q && rdy;
    assign cdb_en = cdb_q && rdy;

    // live done wins, a stalled one is replayed afterwards
    assign fin_en   = done_en || pend_en;
    assign fin_nick = done_en ? done_nick : pend_nick;
    assign fin_data = done_en ? done_data : pend_data;

    // committed store first, else the lowest ready load
    always_comb begin
        sel_en    = 1'b0;
        sel_store = 1'b0;
        sel_nick  = '0;
        if (mem_ready && !req_q) begin
            if (rob_store_en && occupied[rob_store_nick] && is_store[rob_store_nick]
                    && !issued[rob_store_nick]
                    && rs1_valid[rob_store_nick] && rs2_valid[rob_store_nick]) begin
                sel_en    = 1'b1;
                sel_store = 1'b1;
                sel_nick  = rob_store_nick;
            end else begin
                for (int i = slb_entries - 1; i >= 1; i--) begin
                    if (occupied[i] && !is_store[i] && !issued[i] && rs1_valid[i]) begin
                        sel_en   = 1'b1;
                        sel_nick = nick_w'(i);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clr) begin
            occupied <= '0;
            req_q    <= 1'b0;
            cdb_q    <= 1'b0;
            pend_en  <= 1'b0;
        end else if (!rdy) begin
            // everything holds, only the memory keeps going
            if (done_en) begin
                pend_en   <= 1'b1;
                pend_nick <= done_nick;
                pend_data <= done_data;
            end
        end else begin
            // operand wakeup from execute and from our own broadcast
            for (int i = 1; i < slb_entries; i++) begin
                if (occupied[i] && !rs1_valid[i]) begin
                    if (ex_en && rs1_nick[i] == ex_nick) begin
                        rs1_valid[i] <= 1'b1;
                        rs1_data[i]  <= ex_data;
                    end else if (cdb_q && rs1_nick[i] == cdb_nick) begin
                        rs1_valid[i] <= 1'b1;
                        rs1_data[i]  <= cdb_data;
                    end
                end
                if (occupied[i] && !rs2_valid[i]) begin
                    if (ex_en && rs2_nick[i] == ex_nick) begin
                        rs2_valid[i] <= 1'b1;
                        rs2_data[i]  <= ex_data;
                    end else if (cdb_q && rs2_nick[i] == cdb_nick) begin
                        rs2_valid[i] <= 1'b1;
                        rs2_data[i]  <= cdb_data;
                    end
                end
            end

            req_q <= sel_en;
            if (sel_en) begin
                issued[sel_nick] <= 1'b1;
                req_store        <= sel_store;
                req_nick         <= sel_nick;
                req_len          <= len_of(ent_op[sel_nick]);
                req_addr         <= rs1_data[sel_nick] + ent_imm[sel_nick];
                req_data         <= sel_store ? rs2_data[sel_nick] : '0;
                req_signed       <= ent_op[sel_nick] == op_lb || ent_op[sel_nick] == op_lh;
            end

            // completions for cleared tags are dropped here
            pend_en <= 1'b0;
            cdb_q   <= fin_en && occupied[fin_nick];
            if (fin_en && occupied[fin_nick]) begin
                occupied[fin_nick] <= 1'b0;
                cdb_nick           <= fin_nick;
                cdb_data           <= fin_data;
            end

            if (dp_take) begin
                occupied[dp_rd_nick]  <= 1'b1;
                issued[dp_rd_nick]    <= 1'b0;
                is_store[dp_rd_nick]  <= dp_op == op_sb || dp_op == op_sh || dp_op == op_sw;
                ent_op[dp_rd_nick]    <= dp_op;
                ent_imm[dp_rd_nick]   <= dp_imm;
                rs1_nick[dp_rd_nick]  <= dp_rs1_nick;
                rs2_nick[dp_rd_nick]  <= dp_rs2_nick;
                // a tag may be resolved on the buses in the same cycle
                if (dp_rs1_nick != '0 && ex_en && ex_nick == dp_rs1_nick) begin
                    rs1_valid[dp_rd_nick] <= 1'b1;
                    rs1_data[dp_rd_nick]  <= ex_data;
                end else if (dp_rs1_nick != '0 && cdb_q && cdb_nick == dp_rs1_nick) begin
                    rs1_valid[dp_rd_nick] <= 1'b1;
                    rs1_data[dp_rd_nick]  <= cdb_data;
                end else begin
                    rs1_valid[dp_rd_nick] <= dp_rs1_nick == '0;
                    rs1_data[dp_rd_nick]  <= dp_rs1_data;
                end
                if (dp_rs2_nick != '0 && ex_en && ex_nick == dp_rs2_nick) begin
                    rs2_valid[dp_rd_nick] <= 1'b1;
                    rs2_data[dp_rd_nick]  <= ex_data;
                end else if (dp_rs2_nick != '0 && cdb_q && cdb_nick == dp_rs2_nick) begin
                    rs2_valid[dp_rd_nick] <= 1'b1;
                    rs2_data[dp_rd_nick]  <= cdb_data;
                end else begin
                    rs2_valid[dp_rd_nick] <= dp_rs2_nick == '0;
                    rs2_data[dp_rd_nick]  <= dp_rs2_data;
                end
            end
        end
    end

    // a tag is only handed out again after its broadcast
    a_dp_free: assert property (@(posedge clk) disable iff (reset || clr)
        dp_take |-> !occupied[dp_rd_nick]);

    a_dp_nick: assert property (@(posedge clk) disable iff (reset)
        dp_take |-> dp_rd_nick != '0);

    // memory takes a request only while idle
    a_req_idle: assert property (@(posedge clk) disable iff (reset)
        req_en |-> mem_ready);

endmodule

`default_nettype wire

/* source/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // rename tag, tag 0 means operand already present
    localparam int nick_w = 3;

    // one entry per tag, entry 0 never used
    localparam int slb_entries = 1 << nick_w;

    localparam int data_w = 32;
    localparam int addr_w = 32;

    // micro-op codes, anything else is not a memory op
    localparam int op_w = 4;

    localparam logic [op_w-1:0] op_lb  = 4'd1;
    localparam logic [op_w-1:0] op_lh  = 4'd2;
    localparam logic [op_w-1:0] op_lw  = 4'd3;
    localparam logic [op_w-1:0] op_lbu = 4'd4;
    localparam logic [op_w-1:0] op_lhu = 4'd5;
    localparam logic [op_w-1:0] op_sb  = 4'd6;
    localparam logic [op_w-1:0] op_sh  = 4'd7;
    localparam logic [op_w-1:0] op_sw  = 4'd8;

    // access length sent with each memory request
    localparam int len_w = 2;

    localparam logic [len_w-1:0] len_one  = 2'd0;
    localparam logic [len_w-1:0] len_two  = 2'd1;
    localparam logic [len_w-1:0] len_four = 2'd2;

    // data memory geometry and timing
    localparam int mem_words = 64;

    // cycles from request to done, at least 2
    localparam int mem_latency = 2;

    // one memory word, as a whole, as bytes or as halfwords
    // byte 0 and half 0 sit at the low address
    typedef union packed {
        logic [data_w-1:0]  word;
        logic [3:0][7:0]    bytes;
        logic [1:0][15:0]   halves;
    } mem_word_t;

endpackage

`default_nettype wire
